/* hw/gpio_apb_decode.sv */
// apb slave front end
`timescale 1ns/1ns

module gpio_apb_decode
(
  // apb slave side
  input  logic                                    psel,    // slave select
  input  logic                                    penable, // access phase
  input  logic                                    pwrite,  // 1 = write
  input  logic [gpio_bus_pkg::apb_addr_width-1:0] paddr,   // byte address
  input  logic [gpio_bus_pkg::apb_data_width-1:0] pwdata,  // write data
  output logic [gpio_bus_pkg::apb_data_width-1:0] prdata,  // read data

  // register side
  input  logic [gpio_bus_pkg::apb_data_width-1:0] rdata,   // registered read data
  output logic                                    read,    // setup cycle strobe
  output logic                                    write,   // access cycle strobe
  output logic [gpio_bus_pkg::apb_addr_width-1:0] addr,
  output logic [gpio_bus_pkg::apb_data_width-1:0] wdata
);

  import gpio_bus_pkg::*;

  logic setup_phase;  // psel high, penable not yet
  logic access_phase; // second cycle of the transfer

  // ----------------------------------------------------------------------
  // phase decode
  // ----------------------------------------------------------------------
  assign setup_phase  = psel & ~penable;
  assign access_phase = psel & penable;

  // read fires early so the subunit has data registered for the access cycle
  assign read  = setup_phase & ~pwrite;
  assign write = access_phase & pwrite;   // register updates on this edge

  // address and data are stable across both phases
  assign addr  = paddr;
  assign wdata = pwdata;

  // ----------------------------------------------------------------------
  // read data return
  // ----------------------------------------------------------------------
  // only during a read access, idle cycles see zero
  assign prdata = (access_phase & ~pwrite) ? rdata : {apb_data_width{1'b0}};

endmodule

/* hw/gpio_bus_pkg.sv */
// apb bus widths
package gpio_bus_pkg;

  // address bus, covers the 64 byte register window
  localparam int apb_addr_width = 6;

  // data bus, one register per word
  localparam int apb_data_width = 16;

  // pending pin number reported with irq
  localparam int pin_index_width = 4; // log2 of the pin count

  // read data and pin count share a width here, the register map
  // packs one bit per pin into each data word
  // the index width has to cover every pin, 2**4 = 16

  // byte addresses on a 16 bit bus, low two bits stay zero on every
  // mapped register

  // nothing else on this bus, no pready and no pslverr
  // every transfer is a setup cycle then an access cycle

endpackage

/* hw/gpio_irq_combine.sv */
// gpio interrupt combiner
`timescale 1ns/1ns

module gpio_irq_combine
(
  input  logic                                     pclk17,
  input  logic                                     n_reset17, // async, active low
  input  logic [gpio_reg_pkg::gpio_width-1:0]      interrupt, // status vector
  output logic                                     irq,       // any bit pending
  output logic [gpio_bus_pkg::pin_index_width-1:0] irq_pin    // lowest pending pin
);

  import gpio_bus_pkg::*;

  logic                       irq_next;
  logic [pin_index_width-1:0] pin_next;

  // ----------------------------------------------------------------------
  // priority encode, lowest pin first
  // ----------------------------------------------------------------------
  always_comb
  begin
    irq_next = |interrupt;
    pin_next = '0;                        // zero when nothing pending
    // walk down so the lowest set bit is the last one written
    for (int i = $bits(interrupt) - 1; i >= 0; i--)
    begin
      if (interrupt[i])
        pin_next = pin_index_width'(i);
    end
  end

  // ----------------------------------------------------------------------
  // output register, one cycle behind the status
  // ----------------------------------------------------------------------
  always_ff @(posedge pclk17 or negedge n_reset17)
  begin
    if (!n_reset17)
    begin
      irq     <= 1'b0;
      irq_pin <= '0;
    end
    else
    begin
      irq     <= irq_next;
      irq_pin <= pin_next;                // held stable with irq
    end
  end

endmodule

/* hw/gpio_lite_subunit.sv */
// gpio register subunit
`timescale 1ns/1ns

module gpio_lite_subunit
(
  input  logic                                    n_reset17,        // async, active low
  input  logic                                    pclk17,

  // register access strobes from the front end
  input  logic                                    read,             // setup cycle read
  input  logic                                    write,            // access cycle write
  input  logic [gpio_bus_pkg::apb_addr_width-1:0] addr,
  input  logic [gpio_bus_pkg::apb_data_width-1:0] wdata,

  // pins
  input  logic [gpio_reg_pkg::gpio_width-1:0]     pin_in,           // raw, asynchronous
  input  logic [gpio_reg_pkg::gpio_width-1:0]     tri_state_enable, // dft, forces z

  output logic [gpio_reg_pkg::gpio_width-1:0]     interrupt,        // status vector
  output logic [gpio_bus_pkg::apb_data_width-1:0] rdata,            // registered read data
  output logic [gpio_reg_pkg::gpio_width-1:0]     pin_oe_n,         // low = driving
  output logic [gpio_reg_pkg::gpio_width-1:0]     pin_out
);

  import gpio_bus_pkg::*;
  import gpio_reg_pkg::*;

  // software visible registers
  logic [gpio_width-1:0] direction_mode; // 1 = input, 0 = output
  logic [gpio_width-1:0] output_enable;
  logic [gpio_width-1:0] output_value;
  logic [gpio_width-1:0] input_value;    // synchronised pins
  logic [gpio_width-1:0] int_status;     // sticky rising edges

  // synchroniser
  logic [gpio_width-1:0] s_synch_two;    // first stage, at the pin
  logic [gpio_width-1:0] s_synch;        // second stage

  // edge detect
  logic [gpio_width-1:0] int_event;      // rising edge on any pin
  logic [gpio_width-1:0] int_trigger;    // edge on an input pin
  logic                  status_clear;   // read of the status register

  // address decodes
  logic ad_direction_mode;
  logic ad_output_enable;
  logic ad_output_value;
  logic ad_int_status;

  assign ad_direction_mode = (addr == gpr_direction_mode);
  assign ad_output_enable  = (addr == gpr_output_enable);
  assign ad_output_value   = (addr == gpr_output_value);
  assign ad_int_status     = (addr == gpr_int_status);

  // ----------------------------------------------------------------------
  // read-write registers
  // ----------------------------------------------------------------------
  always_ff @(posedge pclk17 or negedge n_reset17)
  begin
    if (!n_reset17)
    begin
      direction_mode <= gprv_direction_mode;
      output_enable  <= gprv_output_enable;
      output_value   <= gprv_output_value;
    end
    else if (write)
    begin
      if (ad_direction_mode)
        direction_mode <= wdata;
      if (ad_output_enable)
        output_enable <= wdata;
      if (ad_output_value)
        output_value <= wdata;          // reaches the pins straight away
    end
  end

  // ----------------------------------------------------------------------
  // input synchroniser
  // ----------------------------------------------------------------------
  // pin -> stage one -> stage two -> input register, three edges
  always_ff @(posedge pclk17 or negedge n_reset17)
  begin
    if (!n_reset17)
    begin
      s_synch_two <= '0;
      s_synch     <= '0;
      input_value <= gprv_input_value;
    end
    else
    begin
      s_synch_two <= pin_in;
      s_synch     <= s_synch_two;
      input_value <= s_synch;
    end
  end

  // ----------------------------------------------------------------------
  // edge interrupts
  // ----------------------------------------------------------------------
  // new 1 in stage two while the input register still holds 0
  assign int_event    = s_synch & ~input_value;
  assign int_trigger  = int_event & direction_mode; // inputs only
  assign status_clear = read & ad_int_status;

  // a trigger on the clearing edge survives
  always_ff @(posedge pclk17 or negedge n_reset17)
  begin
    if (!n_reset17)
      int_status <= gprv_int_status;
    else
      int_status <= (int_status & ~{gpio_width{status_clear}}) | int_trigger;
  end

  assign interrupt = int_status;

  // ----------------------------------------------------------------------
  // read data
  // ----------------------------------------------------------------------
  // taken in the setup cycle, valid through the access cycle
  always_ff @(posedge pclk17 or negedge n_reset17)
  begin
    if (!n_reset17)
      rdata <= '0;
    else if (read)
    begin
      case (addr)
        gpr_direction_mode: rdata <= direction_mode;
        gpr_output_enable:  rdata <= output_enable;
        gpr_output_value:   rdata <= output_value;
        gpr_int_status:     rdata <= int_status;  // value before the clear
        default:            rdata <= input_value; // input register and unmapped
      endcase
    end
    else
      rdata <= {apb_data_width{1'b0}};            // no read, keep zero
  end

  // ----------------------------------------------------------------------
  // pin drive
  // ----------------------------------------------------------------------
  assign pin_out  = output_value;
  // drive only enabled outputs, dft override wins
  assign pin_oe_n = ~(output_enable & ~direction_mode) | tri_state_enable;

endmodule

/* hw/gpio_lite_top.sv */
// apb gpio top level
`timescale 1ns/1ns

module gpio_lite_top
(
  input  logic                                     pclk17,
  input  logic                                     n_reset17,        // async, active low

  // apb
  input  logic                                     psel,
  input  logic                                     penable,
  input  logic                                     pwrite,
  input  logic [gpio_bus_pkg::apb_addr_width-1:0]  paddr,
  input  logic [gpio_bus_pkg::apb_data_width-1:0]  pwdata,
  output logic [gpio_bus_pkg::apb_data_width-1:0]  prdata,

  // pins
  input  logic [gpio_reg_pkg::gpio_width-1:0]      pin_in,
  input  logic [gpio_reg_pkg::gpio_width-1:0]      tri_state_enable, // dft override
  output logic [gpio_reg_pkg::gpio_width-1:0]      pin_out,
  output logic [gpio_reg_pkg::gpio_width-1:0]      pin_oe_n,

  // interrupt
  output logic                                     irq,
  output logic [gpio_bus_pkg::pin_index_width-1:0] irq_pin
);

  import gpio_bus_pkg::*;
  import gpio_reg_pkg::*;

  logic                      read;       // front end -> subunit
  logic                      write;
  logic [apb_addr_width-1:0] addr;
  logic [apb_data_width-1:0] wdata;
  logic [apb_data_width-1:0] rdata;      // subunit -> front end
  logic [gpio_width-1:0]     interrupt;  // subunit -> combiner

  gpio_apb_decode i_decode
  (
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .rdata   (rdata),
    .read    (read),
    .write   (write),
    .addr    (addr),
    .wdata   (wdata),
    .prdata  (prdata)
  );

  gpio_lite_subunit i_subunit
  (
    .n_reset17        (n_reset17),
    .pclk17           (pclk17),
    .read             (read),
    .write            (write),
    .addr             (addr),
    .wdata            (wdata),
    .pin_in           (pin_in),
    .tri_state_enable (tri_state_enable),
    .interrupt        (interrupt),
    .rdata            (rdata),
    .pin_oe_n         (pin_oe_n),
    .pin_out          (pin_out)
  );

  gpio_irq_combine i_irq
  (
    .pclk17    (pclk17),
    .n_reset17 (n_reset17),
    .interrupt (interrupt),
    .irq       (irq),
    .irq_pin   (irq_pin)
  );

endmodule

/* hw/gpio_reg_pkg.sv */
// gpio register map
package gpio_reg_pkg;

  // ----------------------------------------------------------------------
  // block size
  // ----------------------------------------------------------------------
  localparam int gpio_width = 16; // pins in the block

  // ----------------------------------------------------------------------
  // register addresses, byte offsets on the apb address bus
  // ----------------------------------------------------------------------
  localparam logic [gpio_bus_pkg::apb_addr_width-1:0] gpr_direction_mode = 6'h04; // 1 = input
  localparam logic [gpio_bus_pkg::apb_addr_width-1:0] gpr_output_enable  = 6'h08; // oe control
  localparam logic [gpio_bus_pkg::apb_addr_width-1:0] gpr_output_value   = 6'h0C; // pin drive
  localparam logic [gpio_bus_pkg::apb_addr_width-1:0] gpr_input_value    = 6'h10; // read only
  localparam logic [gpio_bus_pkg::apb_addr_width-1:0] gpr_int_status     = 6'h20; // read clears

  // ----------------------------------------------------------------------
  // reset values
  // ----------------------------------------------------------------------
  // all pins come up as outputs with the driver off
  localparam logic [gpio_width-1:0] gprv_direction_mode = 16'h0000; // output mode

  localparam logic [gpio_width-1:0] gprv_output_enable  = 16'h0000; // drivers off

  localparam logic [gpio_width-1:0] gprv_output_value   = 16'h0000; // drive low once enabled

  // sampled side starts empty
  localparam logic [gpio_width-1:0] gprv_input_value    = 16'h0000; // nothing sampled yet

  localparam logic [gpio_width-1:0] gprv_int_status     = 16'h0000; // no pending edges

  // note: gpr_input_value is also the fallback for unmapped reads

endpackage

/* sim/gpio_lite_asserts.sv */
// gpio bus and interrupt assertions
`timescale 1ns/1ns

module gpio_lite_asserts
(
  input logic                                    pclk17,
  input logic                                    n_reset17,
  input logic                                    penable,
  input logic                                    read,      // front end strobes
  input logic                                    write,
  input logic [gpio_bus_pkg::apb_data_width-1:0] prdata,
  input logic [gpio_reg_pkg::gpio_width-1:0]     interrupt, // status vector
  input logic                                    irq
);

  int fail_count = 0; // failed assertions so far

  // ----------------------------------------------------------------------
  // bus side
  // ----------------------------------------------------------------------
  // setup cycle read and access cycle write never overlap
  strobes_exclusive: assert property (@(posedge pclk17) disable iff (!n_reset17)
    !(read && write))
    else
    begin
      fail_count++;
      $error("read and write strobes high in the same cycle");
    end

  // idle and setup cycles return zero
  prdata_idle_zero: assert property (@(posedge pclk17) disable iff (!n_reset17)
    !penable |-> (prdata == '0))
    else
    begin
      fail_count++;
      $error("prdata nonzero while penable is low");
    end

  // ----------------------------------------------------------------------
  // interrupt side
  // ----------------------------------------------------------------------
  // irq is the registered or of the status bits
  irq_follows_status: assert property (@(posedge pclk17) disable iff (!n_reset17)
    irq == $past(|interrupt))
    else
    begin
      fail_count++;
      $error("irq does not match the previous interrupt vector");
    end

endmodule

// internal strobes and status picked up from the top level scope
bind gpio_lite_top gpio_lite_asserts i_asserts
(
  .pclk17    (pclk17),
  .n_reset17 (n_reset17),
  .penable   (penable),
  .read      (read),
  .write     (write),
  .prdata    (prdata),
  .interrupt (interrupt),
  .irq       (irq)
);

/* sim/gpio_lite_tb.sv */
// gpio block testbench
`timescale 1ns/1ns

module gpio_lite_tb;

  import gpio_bus_pkg::*;
  import gpio_reg_pkg::*;

  localparam int         reset_cycles = 3;
  localparam int         table_max    = 128;
  localparam logic [1:0] op_read      = 2'd0;
  localparam logic [1:0] op_write     = 2'd1;
  localparam logic [1:0] op_pins      = 2'd2; // new pin pattern and dft override

  typedef struct packed
  {
    logic [1:0]                 op;
    logic [apb_addr_width-1:0]  addr;
    logic [apb_data_width-1:0]  data;      // write data or tri_state_enable for op_pins
    logic [gpio_width-1:0]      pins;
    logic [apb_data_width-1:0]  exp_rdata; // read ops only
    logic [gpio_width-1:0]      exp_out;
    logic [gpio_width-1:0]      exp_oe_n;
    logic                       exp_irq;
    logic [pin_index_width-1:0] exp_pin;
  } entry_t;

  logic                       pclk17 = 1'b0;
  logic                       n_reset17;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [apb_addr_width-1:0]  paddr;
  logic [apb_data_width-1:0]  pwdata;
  logic [apb_data_width-1:0]  prdata;
  logic [gpio_width-1:0]      pin_in;
  logic [gpio_width-1:0]      tri_state_enable;
  logic [gpio_width-1:0]      pin_out;
  logic [gpio_width-1:0]      pin_oe_n;
  logic                       irq;
  logic [pin_index_width-1:0] irq_pin;

  // reference model state
  logic [gpio_width-1:0] m_dir;
  logic [gpio_width-1:0] m_oe;
  logic [gpio_width-1:0] m_ov;
  logic [gpio_width-1:0] m_in;     // steady pin pattern = input register
  logic [gpio_width-1:0] m_status;
  logic [gpio_width-1:0] m_tse;

  entry_t tbl [table_max];
  int     table_len   = 0;
  bit     table_ready = 1'b0;

  always #2 pclk17 = ~pclk17; // 4 ns period

  gpio_lite_top i_dut
  (
    .pclk17           (pclk17),
    .n_reset17        (n_reset17),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pin_in           (pin_in),
    .tri_state_enable (tri_state_enable),
    .pin_out          (pin_out),
    .pin_oe_n         (pin_oe_n),
    .irq              (irq),
    .irq_pin          (irq_pin)
  );

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  // driver on only for an enabled output pin without the override
  function automatic logic [gpio_width-1:0] expected_oe_n(input logic [gpio_width-1:0] oe,
                                                          input logic [gpio_width-1:0] dir,
                                                          input logic [gpio_width-1:0] tse);
    logic [gpio_width-1:0] r;
    r = '1;
    for (int i = 0; i < gpio_width; i++)
      if (oe[i] && !dir[i] && !tse[i])
        r[i] = 1'b0;
    return r;
  endfunction

  function automatic logic [pin_index_width-1:0] lowest_pending(input logic [gpio_width-1:0] st);
    int   idx;
    logic found;
    idx   = 0;
    found = 1'b0;
    for (int i = 0; i < gpio_width; i++)
    begin
      if (st[i] && !found)
      begin
        idx   = i;
        found = 1'b1;
      end
    end
    return idx[pin_index_width-1:0];
  endfunction

  function automatic logic [apb_addr_width-1:0] pick_unmapped(input int unsigned n);
    case (n % 6)
      0:       return 6'h00;
      1:       return 6'h14;
      2:       return 6'h18;
      3:       return 6'h1C;
      4:       return 6'h24;
      default: return 6'h3C; // top of the window
    endcase
  endfunction

  // snapshot the model after an op into the next table slot
  task automatic push_entry(input logic [1:0] op, input logic [apb_addr_width-1:0] a,
                            input logic [apb_data_width-1:0] d,
                            input logic [apb_data_width-1:0] rd);
    entry_t e;
    e.op        = op;
    e.addr      = a;
    e.data      = d;
    e.pins      = m_in;
    e.exp_rdata = rd;
    e.exp_out   = m_ov;
    e.exp_oe_n  = expected_oe_n(m_oe, m_dir, m_tse);
    e.exp_irq   = |m_status;
    e.exp_pin   = lowest_pending(m_status);
    tbl[table_len] = e;
    table_len++;
  endtask

  task automatic add_write(input logic [apb_addr_width-1:0] a, input logic [apb_data_width-1:0] d);
    if (a == gpr_direction_mode)
      m_dir = d;
    else if (a == gpr_output_enable)
      m_oe = d;
    else if (a == gpr_output_value)
      m_ov = d;
    push_entry(op_write, a, d, '0);
  endtask

  task automatic add_read(input logic [apb_addr_width-1:0] a);
    logic [apb_data_width-1:0] exp;
    if (a == gpr_direction_mode)
      exp = m_dir;
    else if (a == gpr_output_enable)
      exp = m_oe;
    else if (a == gpr_output_value)
      exp = m_ov;
    else if (a == gpr_int_status)
    begin
      exp      = m_status; // old value comes back
      m_status = '0;
    end
    else
      exp = m_in;          // input register and every unmapped address
    push_entry(op_read, a, '0, exp);
  endtask

  task automatic add_pins(input logic [gpio_width-1:0] p, input logic [gpio_width-1:0] tse);
    m_status = m_status | (p & ~m_in & m_dir); // rising edges on input pins only
    m_in     = p;
    m_tse    = tse;
    push_entry(op_pins, '0, tse, '0);
  endtask

  task automatic build_table();
    m_dir    = gprv_direction_mode;
    m_oe     = gprv_output_enable;
    m_ov     = gprv_output_value;
    m_in     = gprv_input_value;
    m_status = gprv_int_status;
    m_tse    = '0;
    // everything reads zero straight out of reset
    add_read(gpr_direction_mode);
    add_read(gpr_output_enable);
    add_read(gpr_output_value);
    add_read(gpr_input_value);
    add_read(gpr_int_status);
    add_read(6'h00);
    add_read(6'h3C);
    // register read back and pin drive
    for (int n = 0; n < 4; n++)
    begin
      add_write(gpr_direction_mode, 16'($urandom()));
      add_write(gpr_output_enable, 16'($urandom()));
      add_write(gpr_output_value, 16'($urandom()));
      add_read(gpr_direction_mode);
      add_read(gpr_output_enable);
      add_read(gpr_output_value);
    end
    // synchroniser and unmapped reads
    for (int n = 0; n < 6; n++)
    begin
      add_pins(16'($urandom()), 16'($urandom()));
      add_read(gpr_input_value);
      add_read(pick_unmapped($urandom()));
      add_read(gpr_int_status);   // drain edges from this pattern
    end
    // edge interrupts
    for (int n = 0; n < 8; n++)
    begin
      add_write(gpr_direction_mode, 16'($urandom()));
      add_pins(16'h0000, m_tse);  // falling edges only
      add_read(gpr_int_status);
      add_pins(16'($urandom()), 16'($urandom()));
      add_pins(16'($urandom()), m_tse); // more edges pile up
      add_read(gpr_int_status);
      add_read(gpr_int_status);   // cleared by the one before
    end
  endtask

  // ----------------------------------------------------------------------
  // bus and pin drivers start and end on a falling edge
  // ----------------------------------------------------------------------
  task automatic apb_write(input logic [apb_addr_width-1:0] a, input logic [apb_data_width-1:0] d);
    psel    = 1'b1; // setup
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = a;
    pwdata  = d;
    @(negedge pclk17);
    penable = 1'b1; // register takes the data on the next edge
    @(negedge pclk17);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [apb_addr_width-1:0] a, output logic [apb_data_width-1:0] d);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = a;
    @(negedge pclk17);
    penable = 1'b1;
    #1 d = prdata;  // mid access cycle
    @(negedge pclk17);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // 3 edges to the input register and one more for irq
  task automatic apply_pins(input logic [gpio_width-1:0] p, input logic [gpio_width-1:0] tse);
    pin_in           = p;
    tri_state_enable = tse;
    repeat (4) @(negedge pclk17);
  endtask

  // ----------------------------------------------------------------------
  // checking
  // ----------------------------------------------------------------------
  task automatic report_failure();
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] got);
    assert (got === exp)
    else
    begin
      $display("Fail %s exp %h got %h", name, exp, got);
      report_failure();
    end
  endtask

  // bound checker failures end the run as well
  always @(i_dut.i_asserts.fail_count)
  begin
    if (i_dut.i_asserts.fail_count != 0)
    begin
      $display("A concurrent assertion in the bound checker failed");
      report_failure();
    end
  end

  initial
  begin
    logic [apb_data_width-1:0] got;
    void'($urandom(32'hed2a));
    n_reset17        = 1'b0;
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    paddr            = '0;
    pwdata           = '0;
    pin_in           = '0;
    tri_state_enable = '0;
    build_table();
    table_ready = 1'b1;
    repeat (reset_cycles) @(negedge pclk17);
    n_reset17 = 1'b1;
    #1;
    check_value("pin_oe_n", 16'hFFFF, pin_oe_n); // everything tri-stated
    check_value("irq", 16'h0000, {15'd0, irq});
    check_value("prdata", 16'h0000, prdata);
    @(negedge pclk17);
    for (int i = 0; i < table_len; i++)
    begin
      case (tbl[i].op)
        op_write: apb_write(tbl[i].addr, tbl[i].data);
        op_read:
        begin
          apb_read(tbl[i].addr, got);
          check_value("prdata", tbl[i].exp_rdata, got);
        end
        default: apply_pins(tbl[i].pins, tbl[i].data);
      endcase
      #1;
      check_value("pin_out", tbl[i].exp_out, pin_out);
      check_value("pin_oe_n", tbl[i].exp_oe_n, pin_oe_n);
      check_value("irq", {15'd0, tbl[i].exp_irq}, {15'd0, irq});
      check_value("irq_pin", {12'd0, tbl[i].exp_pin}, {12'd0, irq_pin});
      @(negedge pclk17);
    end
    $display("Simulation passed");
    $finish;
  end

  // watchdog with a generous budget per entry
  initial
  begin
    wait (table_ready);
    repeat (table_len * 20 + reset_cycles + 4) @(posedge pclk17);
    $display("Watchdog timeout, the test table did not finish in time");
    report_failure();
  end

endmodule

/* vlog.f */
hw/gpio_bus_pkg.sv
hw/gpio_reg_pkg.sv
hw/gpio_apb_decode.sv
hw/gpio_lite_subunit.sv
hw/gpio_irq_combine.sv
hw/gpio_lite_top.sv
sim/gpio_lite_asserts.sv
sim/gpio_lite_tb.sv
